//--- common/vint_pkg.sv
// Vector integer unit shared definitions
// Element widths, operand types and RISC-V vector opcode encodings
`default_nettype none

package vint_pkg;

    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [2*DATA_WIDTH-1:0] wide_t;
    // Operand times one byte of the other operand
    typedef logic [DATA_WIDTH+7:0]   partial_t;
    typedef logic [5:0]              funct6_t;
    typedef logic [2:0]              funct3_t;

    // Classes routed to the multi-cycle units
    localparam funct3_t FUNCT3_OPMVV = 3'b010;
    localparam funct3_t FUNCT3_OPMVX = 3'b110;

    // Single-cycle operations
    localparam funct6_t FUNCT6_VADD  = 6'b000000;
    localparam funct6_t FUNCT6_VSUB  = 6'b000010;
    localparam funct6_t FUNCT6_VRSUB = 6'b000011;
    localparam funct6_t FUNCT6_VMINU = 6'b000100;
    localparam funct6_t FUNCT6_VMIN  = 6'b000101;
    localparam funct6_t FUNCT6_VMAXU = 6'b000110;
    localparam funct6_t FUNCT6_VMAX  = 6'b000111;
    localparam funct6_t FUNCT6_VAND  = 6'b001001;
    localparam funct6_t FUNCT6_VOR   = 6'b001010;
    localparam funct6_t FUNCT6_VXOR  = 6'b001011;
    localparam funct6_t FUNCT6_VSLL  = 6'b100101;
    localparam funct6_t FUNCT6_VSRL  = 6'b101000;
    localparam funct6_t FUNCT6_VSRA  = 6'b101001;
    localparam funct6_t FUNCT6_VMV   = 6'b010111;

    // Multiply family, OPMVV and OPMVX only
    localparam funct6_t FUNCT6_VMULHU  = 6'b100100;
    localparam funct6_t FUNCT6_VMUL    = 6'b100101;
    localparam funct6_t FUNCT6_VMULHSU = 6'b100110;
    localparam funct6_t FUNCT6_VMULH   = 6'b100111;

    // Divide family, OPMVV and OPMVX only
    localparam funct6_t FUNCT6_VDIVU = 6'b100000;
    localparam funct6_t FUNCT6_VDIV  = 6'b100001;
    localparam funct6_t FUNCT6_VREMU = 6'b100010;
    localparam funct6_t FUNCT6_VREM  = 6'b100011;

    localparam int DIV_STAGES         = 4;
    localparam int DIV_BITS_PER_STAGE = DATA_WIDTH / DIV_STAGES;

endpackage

`default_nettype wire

//--- common/vint_req_if.sv
// Issued operation as seen by the three execution units
`timescale 1ns/1ps
`default_nettype none

interface vint_req_if;

    logic              alu_valid;
    logic              mul_valid;
    logic              div_valid;
    vint_pkg::funct6_t funct6;
    vint_pkg::data_t   operand_a;
    vint_pkg::data_t   operand_b;
    logic              mask;

    modport issue (output alu_valid, mul_valid, div_valid, funct6, operand_a, operand_b, mask);
    modport alu   (input  alu_valid, mul_valid, div_valid, funct6, operand_a, operand_b, mask);
    modport mul   (input  alu_valid, mul_valid, div_valid, funct6, operand_a, operand_b, mask);
    modport div   (input  alu_valid, mul_valid, div_valid, funct6, operand_a, operand_b, mask);

endinterface

`default_nettype wire

//--- div/vint_div.sv
// Four-stage divider for the vdiv family
// Works on magnitudes, restores the signs after the last step
`timescale 1ns/1ps
`default_nettype none

module vint_div (
    input  wire logic         clk,
    input  wire logic         rst_n,
    vint_req_if.div           req,
    output logic              ready_o,
    output vint_pkg::data_t   result_o
);

    localparam int DW     = vint_pkg::DATA_WIDTH;
    localparam int STAGES = vint_pkg::DIV_STAGES;

    logic            signed_op;
    logic            rem_op;

    // Index s holds the inputs of step s
    vint_pkg::data_t quot_in  [STAGES];
    vint_pkg::data_t rem_in   [STAGES];
    vint_pkg::data_t divisor  [STAGES];
    vint_pkg::data_t quot_out [STAGES];
    vint_pkg::data_t rem_out  [STAGES];
    logic            valid_s  [STAGES];
    logic            qsign_s  [STAGES];
    logic            rsign_s  [STAGES];
    logic            rsel_s   [STAGES];
    logic            mask_s   [STAGES];

    vint_pkg::data_t quot_final;
    vint_pkg::data_t rem_final;

    always_comb begin
        case (req.funct6)
            vint_pkg::FUNCT6_VDIV:  {signed_op, rem_op} = 2'b10;
            vint_pkg::FUNCT6_VREM:  {signed_op, rem_op} = 2'b11;
            vint_pkg::FUNCT6_VREMU: {signed_op, rem_op} = 2'b01;
            default:                {signed_op, rem_op} = 2'b00;
        endcase
    end

    //========================================
    // EX1 operand magnitudes
    //========================================
    // Dividend is b, divisor is a
    assign quot_in[0] = (signed_op && req.operand_b[DW-1]) ? -req.operand_b : req.operand_b;
    assign divisor[0] = (signed_op && req.operand_a[DW-1]) ? -req.operand_a : req.operand_a;
    assign rem_in[0]  = '0;
    assign valid_s[0] = req.div_valid;
    assign qsign_s[0] = signed_op & (req.operand_a[DW-1] ^ req.operand_b[DW-1]);
    assign rsign_s[0] = signed_op & req.operand_b[DW-1];
    assign rsel_s[0]  = rem_op;
    assign mask_s[0]  = req.mask;

    //========================================
    // Steps and stage registers
    //========================================
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        vint_div_step u_step (
            .quotient_i  (quot_in[s]),
            .remainder_i (rem_in[s]),
            .divisor_i   (divisor[s]),
            .quotient_o  (quot_out[s]),
            .remainder_o (rem_out[s])
        );

        if (s < STAGES-1) begin : g_reg
            always_ff @(posedge clk) begin
                if (valid_s[s]) begin
                    quot_in[s+1] <= quot_out[s];
                    rem_in[s+1]  <= rem_out[s];
                    divisor[s+1] <= divisor[s];
                    qsign_s[s+1] <= qsign_s[s];
                    rsign_s[s+1] <= rsign_s[s];
                    rsel_s[s+1]  <= rsel_s[s];
                    mask_s[s+1]  <= mask_s[s];
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_s[s+1] <= 1'b0;
                end else begin
                    valid_s[s+1] <= valid_s[s];
                end
            end
        end
    end

    //========================================
    // EX4 sign correction
    //========================================
    assign quot_final = qsign_s[STAGES-1] ? -quot_out[STAGES-1] : quot_out[STAGES-1];
    assign rem_final  = rsign_s[STAGES-1] ? -rem_out[STAGES-1]  : rem_out[STAGES-1];

    assign ready_o  = valid_s[STAGES-1];
    assign result_o = !mask_s[STAGES-1] ? '0 :
                      rsel_s[STAGES-1]  ? rem_final : quot_final;

endmodule

`default_nettype wire

//--- div/vint_div_step.sv
// One divider stage, eight shift-and-subtract iterations
`timescale 1ns/1ps
`default_nettype none

module vint_div_step (
    input  wire vint_pkg::data_t quotient_i,
    input  wire vint_pkg::data_t remainder_i,
    input  wire vint_pkg::data_t divisor_i,
    output vint_pkg::data_t      quotient_o,
    output vint_pkg::data_t      remainder_o
);

    localparam int DW = vint_pkg::DATA_WIDTH;

    always_comb begin
        logic [DW:0]     shifted;
        vint_pkg::data_t quot;
        vint_pkg::data_t rem;

        quot = quotient_i;
        rem  = remainder_i;
        for (int i = 0; i < vint_pkg::DIV_BITS_PER_STAGE; i++) begin
            // Extra bit keeps divisors above 2^31 exact
            shifted = {rem, quot[DW-1]};
            quot    = quot << 1;
            if (shifted >= {1'b0, divisor_i}) begin
                shifted = shifted - {1'b0, divisor_i};
                quot[0] = 1'b1;
            end
            rem = shifted[DW-1:0];
        end
        quotient_o  = quot;
        remainder_o = rem;
    end

endmodule

`default_nettype wire

//--- mul/vint_mul.sv
// Three-stage multiplier for the vmul family
// Byte partial products in ex1, summed in ex2, sign fixed in ex3
`timescale 1ns/1ps
`default_nettype none

module vint_mul (
    input  wire logic         clk,
    input  wire logic         rst_n,
    vint_req_if.mul           req,
    output logic              ready_o,
    output vint_pkg::data_t   result_o
);

    localparam int DW = vint_pkg::DATA_WIDTH;

    logic              signed_a;
    logic              signed_b;
    logic              upper;
    logic              sign_ex1;
    vint_pkg::data_t   mag_a;
    vint_pkg::data_t   mag_b;
    vint_pkg::partial_t pp_ex1 [4];

    vint_pkg::partial_t pp_ex2 [4];
    logic              valid_ex2;
    logic              sign_ex2;
    logic              upper_ex2;
    logic              mask_ex2;
    vint_pkg::wide_t   sum_ex2;

    vint_pkg::wide_t   sum_ex3;
    logic              valid_ex3;
    logic              sign_ex3;
    logic              upper_ex3;
    logic              mask_ex3;
    vint_pkg::wide_t   product_ex3;

    //========================================
    // EX1 decode and partial products
    //========================================
    always_comb begin
        signed_a = 1'b0;
        signed_b = 1'b0;
        upper    = 1'b1;
        case (req.funct6)
            vint_pkg::FUNCT6_VMUL: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
                upper    = 1'b0;
            end
            vint_pkg::FUNCT6_VMULH: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            // b signed, a unsigned
            vint_pkg::FUNCT6_VMULHSU: signed_b = 1'b1;
            default: ;
        endcase
    end

    assign mag_a    = (signed_a && req.operand_a[DW-1]) ? -req.operand_a : req.operand_a;
    assign mag_b    = (signed_b && req.operand_b[DW-1]) ? -req.operand_b : req.operand_b;
    assign sign_ex1 = signed_a ? (req.operand_a[DW-1] ^ req.operand_b[DW-1]) :
                      signed_b ? req.operand_b[DW-1] : 1'b0;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            pp_ex1[k] = vint_pkg::partial_t'(mag_a) * vint_pkg::partial_t'(mag_b[8*k +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (req.mul_valid) begin
            pp_ex2    <= pp_ex1;
            sign_ex2  <= sign_ex1;
            upper_ex2 <= upper;
            mask_ex2  <= req.mask;
        end
    end

    //========================================
    // EX2 partial product sum
    //========================================
    always_comb begin
        sum_ex2 = '0;
        for (int k = 0; k < 4; k++) begin
            sum_ex2 = sum_ex2 + (vint_pkg::wide_t'(pp_ex2[k]) << (8*k));
        end
    end

    always_ff @(posedge clk) begin
        if (valid_ex2) begin
            sum_ex3   <= sum_ex2;
            sign_ex3  <= sign_ex2;
            upper_ex3 <= upper_ex2;
            mask_ex3  <= mask_ex2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_ex2 <= 1'b0;
            valid_ex3 <= 1'b0;
        end else begin
            valid_ex2 <= req.mul_valid;
            valid_ex3 <= valid_ex2;
        end
    end

    //========================================
    // EX3 sign fix and half select
    //========================================
    assign product_ex3 = sign_ex3 ? -sum_ex3 : sum_ex3;

    assign ready_o  = valid_ex3;
    assign result_o = !mask_ex3 ? '0 :
                      upper_ex3 ? product_ex3[DW +: DW] : product_ex3[0 +: DW];

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
common/vint_pkg.sv
common/vint_req_if.sv
verilog/vint_issue.sv
verilog/vint_alu.sv
mul/vint_mul.sv
div/vint_div_step.sv
div/vint_div.sv
verilog/vint_unit.sv
verification/vint_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the vint_unit regression with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project directory"
    exit 1
fi

verilator --binary --timing -j 0 --top-module vint_tb -f project.f -Mdir obj_dir -o vint_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vint_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

echo "Simulation exited cleanly"
exit 0

//--- verification/vint_ref.svh
// Reference model for the vector integer unit
// Expected result of one operation from the operation rules
`ifndef VINT_REF_SVH
`define VINT_REF_SVH

// Dividend is b and divisor is a, signs restored after a magnitude divide
function automatic vint_pkg::data_t expected_divide(
    input vint_pkg::data_t a,
    input vint_pkg::data_t b,
    input logic            is_signed,
    input logic            want_rem
);
    logic            neg_n;
    logic            neg_d;
    vint_pkg::data_t mag_n;
    vint_pkg::data_t mag_d;
    vint_pkg::data_t quot;
    vint_pkg::data_t rem;

    neg_n = is_signed & b[31];
    neg_d = is_signed & a[31];
    mag_n = neg_n ? -b : b;
    mag_d = neg_d ? -a : a;
    // Divide by zero gives an all-ones quotient and keeps the dividend
    if (mag_d == '0) begin
        quot = '1;
        rem  = mag_n;
    end else begin
        quot = mag_n / mag_d;
        rem  = mag_n % mag_d;
    end
    quot = (neg_n ^ neg_d) ? -quot : quot;
    rem  = neg_n ? -rem : rem;
    return want_rem ? rem : quot;
endfunction

function automatic vint_pkg::data_t vint_ref(
    input vint_pkg::funct3_t f3,
    input vint_pkg::funct6_t f6,
    input vint_pkg::data_t   a,
    input vint_pkg::data_t   b,
    input logic              m
);
    logic [63:0]     prod_ss;
    logic [63:0]     prod_su;
    logic [63:0]     prod_uu;
    vint_pkg::data_t res;

    // Products modulo 2^64 of the sign- or zero-extended operands
    prod_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    prod_su = {32'b0, a} * {{32{b[31]}}, b};
    prod_uu = {32'b0, a} * {32'b0, b};
    res     = '0;
    if (f3 == vint_pkg::FUNCT3_OPMVV || f3 == vint_pkg::FUNCT3_OPMVX) begin
        case (f6)
            vint_pkg::FUNCT6_VMUL:    res = prod_ss[31:0];
            vint_pkg::FUNCT6_VMULH:   res = prod_ss[63:32];
            vint_pkg::FUNCT6_VMULHSU: res = prod_su[63:32];
            vint_pkg::FUNCT6_VMULHU:  res = prod_uu[63:32];
            vint_pkg::FUNCT6_VDIV:    res = expected_divide(a, b, 1'b1, 1'b0);
            vint_pkg::FUNCT6_VDIVU:   res = expected_divide(a, b, 1'b0, 1'b0);
            vint_pkg::FUNCT6_VREM:    res = expected_divide(a, b, 1'b1, 1'b1);
            vint_pkg::FUNCT6_VREMU:   res = expected_divide(a, b, 1'b0, 1'b1);
            default:                  res = '0;
        endcase
    end else begin
        case (f6)
            vint_pkg::FUNCT6_VADD:  res = a + b;
            vint_pkg::FUNCT6_VSUB:  res = b - a;
            vint_pkg::FUNCT6_VRSUB: res = a - b;
            vint_pkg::FUNCT6_VAND:  res = a & b;
            vint_pkg::FUNCT6_VOR:   res = a | b;
            vint_pkg::FUNCT6_VXOR:  res = a ^ b;
            vint_pkg::FUNCT6_VSLL:  res = b << a[4:0];
            vint_pkg::FUNCT6_VSRL:  res = b >> a[4:0];
            vint_pkg::FUNCT6_VSRA:  res = $signed(b) >>> a[4:0];
            vint_pkg::FUNCT6_VMINU: res = (b < a) ? b : a;
            vint_pkg::FUNCT6_VMIN:  res = ($signed(b) < $signed(a)) ? b : a;
            vint_pkg::FUNCT6_VMAXU: res = (b > a) ? b : a;
            vint_pkg::FUNCT6_VMAX:  res = ($signed(b) > $signed(a)) ? b : a;
            vint_pkg::FUNCT6_VMV:   res = a;
            default:                res = '0;
        endcase
    end
    return m ? res : '0;
endfunction

`endif

//--- verification/vint_tb.sv
// Testbench for the vector integer unit
// Random and corner-case operations checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module vint_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 6;
    localparam int ALU_COUNT    = 14 * 8;
    localparam int MUL_COUNT    = 4 * 12;
    localparam int DIV_COUNT    = 4 * 12;
    localparam int MIX_COUNT    = 160;
    localparam int MASK_COUNT   = 30;
    localparam int BAD_COUNT    = 12;
    localparam int TOTAL_OPS    = ALU_COUNT + MUL_COUNT + DIV_COUNT + MIX_COUNT
                                  + MASK_COUNT + BAD_COUNT;
    localparam int WATCHDOG_NS  = TOTAL_OPS * CLK_PERIOD + 100 * CLK_PERIOD;

    localparam vint_pkg::funct6_t ALU_CODES [14] = '{
        vint_pkg::FUNCT6_VADD, vint_pkg::FUNCT6_VSUB, vint_pkg::FUNCT6_VRSUB,
        vint_pkg::FUNCT6_VAND, vint_pkg::FUNCT6_VOR, vint_pkg::FUNCT6_VXOR,
        vint_pkg::FUNCT6_VSLL, vint_pkg::FUNCT6_VSRL, vint_pkg::FUNCT6_VSRA,
        vint_pkg::FUNCT6_VMINU, vint_pkg::FUNCT6_VMIN, vint_pkg::FUNCT6_VMAXU,
        vint_pkg::FUNCT6_VMAX, vint_pkg::FUNCT6_VMV
    };
    localparam vint_pkg::funct6_t MUL_CODES [4] = '{
        vint_pkg::FUNCT6_VMUL, vint_pkg::FUNCT6_VMULH,
        vint_pkg::FUNCT6_VMULHSU, vint_pkg::FUNCT6_VMULHU
    };
    localparam vint_pkg::funct6_t DIV_CODES [4] = '{
        vint_pkg::FUNCT6_VDIV, vint_pkg::FUNCT6_VDIVU,
        vint_pkg::FUNCT6_VREM, vint_pkg::FUNCT6_VREMU
    };
    // Opcodes that no unit accepts
    localparam vint_pkg::funct6_t BAD_CODES [4] = '{
        6'b111111, 6'b001100, 6'b011000, 6'b110001
    };

    typedef struct packed {
        logic [31:0]     due;
        vint_pkg::data_t value;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              valid;
    vint_pkg::data_t   data_a;
    vint_pkg::data_t   data_b;
    vint_pkg::funct6_t funct6;
    vint_pkg::funct3_t funct3;
    logic              mask;
    logic              ready_ex1;
    logic              ready_ex3;
    logic              ready_ex4;
    vint_pkg::data_t   result_ex1;
    vint_pkg::data_t   result_ex3;
    vint_pkg::data_t   result_ex4;

    integer            seed;
    int                cycle = 0;
    expect_t           ex1_q [$];
    expect_t           ex3_q [$];
    expect_t           ex4_q [$];

    `include "vint_ref.svh"

    vint_unit u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_i         (valid),
        .data_a_i        (data_a),
        .data_b_i        (data_b),
        .funct6_i        (funct6),
        .funct3_i        (funct3),
        .mask_i          (mask),
        .ready_res_ex1_o (ready_ex1),
        .result_ex1_o    (result_ex1),
        .ready_res_ex3_o (ready_ex3),
        .result_ex3_o    (result_ex3),
        .ready_res_ex4_o (ready_ex4),
        .result_ex4_o    (result_ex4)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    //========================================
    // Failure reporting and checks
    //========================================
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Head of the queue is due when the cycle count reaches its issue cycle plus latency
    task automatic compare_stage(input int stage, input logic ready,
                                 input vint_pkg::data_t result);
        expect_t head;
        logic    pending;

        head = '0;
        case (stage)
            1: pending = (ex1_q.size() > 0);
            3: pending = (ex3_q.size() > 0);
            default: pending = (ex4_q.size() > 0);
        endcase
        if (pending) begin
            case (stage)
                1: head = ex1_q[0];
                3: head = ex3_q[0];
                default: head = ex4_q[0];
            endcase
        end
        if (ready && !pending) begin
            $display("[ERROR] %0t ns: unexpected result on the ex%0d port", $time, stage);
            abort_run();
        end else if (pending && head.due == cycle) begin
            check_value($sformatf("ex%0d ready", stage), 32'(ready), 32'd1);
            check_value($sformatf("ex%0d result", stage), result, head.value);
            case (stage)
                1: void'(ex1_q.pop_front());
                3: void'(ex3_q.pop_front());
                default: void'(ex4_q.pop_front());
            endcase
        end else if (ready) begin
            check_value($sformatf("ex%0d arrival cycle", stage), cycle, head.due);
        end
    endtask

    always @(negedge clk) begin
        compare_stage(1, ready_ex1, result_ex1);
        compare_stage(3, ready_ex3, result_ex3);
        compare_stage(4, ready_ex4, result_ex4);
    end

    //========================================
    // Stimulus helpers
    //========================================
    // Result port of an operation, 0 when no unit takes it
    function automatic int result_stage(input vint_pkg::funct3_t f3,
                                        input vint_pkg::funct6_t f6);
        int stage;

        stage = 0;
        if (f3 == vint_pkg::FUNCT3_OPMVV || f3 == vint_pkg::FUNCT3_OPMVX) begin
            for (int k = 0; k < 4; k++) begin
                if (f6 == MUL_CODES[k])
                    stage = 3;
                if (f6 == DIV_CODES[k])
                    stage = 4;
            end
        end else begin
            for (int k = 0; k < 14; k++) begin
                if (f6 == ALU_CODES[k])
                    stage = 1;
            end
        end
        return stage;
    endfunction

    // Mostly random, with signed extremes and zero mixed in
    function automatic vint_pkg::data_t pick_operand();
        vint_pkg::data_t value;

        case ({$random(seed)} % 8)
            0: value = 32'h8000_0000;
            1: value = 32'h7fff_ffff;
            2: value = 32'hffff_ffff;
            3: value = 32'h0000_0001;
            4: value = '0;
            default: value = vint_pkg::data_t'($random(seed));
        endcase
        return value;
    endfunction

    function automatic vint_pkg::funct3_t alu_class();
        vint_pkg::funct3_t f3;

        f3 = vint_pkg::funct3_t'($random(seed));
        if (f3 == vint_pkg::FUNCT3_OPMVV || f3 == vint_pkg::FUNCT3_OPMVX)
            f3 = 3'b000;
        return f3;
    endfunction

    function automatic vint_pkg::funct3_t multi_class();
        return ($random(seed) & 1) ? vint_pkg::FUNCT3_OPMVX : vint_pkg::FUNCT3_OPMVV;
    endfunction

    task automatic issue_op(input vint_pkg::funct3_t f3, input vint_pkg::funct6_t f6,
                            input vint_pkg::data_t a, input vint_pkg::data_t b,
                            input logic m);
        expect_t entry;
        int      stage;

        @(posedge clk);
        #DRIVE_DELAY;
        valid       = 1'b1;
        funct3      = f3;
        funct6      = f6;
        data_a      = a;
        data_b      = b;
        mask        = m;
        stage       = result_stage(f3, f6);
        entry.value = vint_ref(f3, f6, a, b, m);
        case (stage)
            1: begin
                entry.due = cycle;
                ex1_q.push_back(entry);
            end
            3: begin
                entry.due = cycle + 2;
                ex3_q.push_back(entry);
            end
            4: begin
                entry.due = cycle + 3;
                ex4_q.push_back(entry);
            end
            default: ;
        endcase
    endtask

    // Any known operation on a randomly chosen unit
    task automatic issue_random(input logic m);
        int unit_sel;

        unit_sel = int'({$random(seed)} % 3);
        case (unit_sel)
            0: issue_op(alu_class(), ALU_CODES[{$random(seed)} % 14],
                        vint_pkg::data_t'($random(seed)), vint_pkg::data_t'($random(seed)), m);
            1: issue_op(multi_class(), MUL_CODES[{$random(seed)} % 4],
                        pick_operand(), pick_operand(), m);
            default: issue_op(multi_class(), DIV_CODES[{$random(seed)} % 4],
                              pick_operand(), pick_operand(), m);
        endcase
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            valid = 1'b0;
        end
    endtask

    //========================================
    // Test sequence
    //========================================
    initial begin
        vint_pkg::data_t divisor;

        seed   = 32'h1f9c_96c5;
        rst_n  = 1'b0;
        valid  = 1'b0;
        data_a = '0;
        data_b = '0;
        funct6 = '0;
        funct3 = '0;
        mask   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        idle_cycles(2);

        // Single-cycle opcodes
        for (int op = 0; op < 14; op++) begin
            for (int n = 0; n < 8; n++) begin
                issue_op(alu_class(), ALU_CODES[op], vint_pkg::data_t'($random(seed)),
                         vint_pkg::data_t'($random(seed)), 1'b1);
            end
        end
        idle_cycles(DRAIN_CYCLES);

        // Multiplies back to back
        for (int op = 0; op < 4; op++) begin
            for (int n = 0; n < 12; n++) begin
                issue_op(multi_class(), MUL_CODES[op], pick_operand(), pick_operand(), 1'b1);
            end
        end
        idle_cycles(DRAIN_CYCLES);

        // Divides back to back, every fourth one by zero
        for (int op = 0; op < 4; op++) begin
            for (int n = 0; n < 12; n++) begin
                divisor = (n % 4 == 0) ? '0 : pick_operand();
                issue_op(multi_class(), DIV_CODES[op], divisor, pick_operand(), 1'b1);
            end
        end
        idle_cycles(DRAIN_CYCLES);

        // Overlapping traffic on all three units
        repeat (MIX_COUNT) issue_random(({$random(seed)} % 8) != 0);
        idle_cycles(DRAIN_CYCLES);

        repeat (MASK_COUNT) issue_random(1'b0);
        idle_cycles(DRAIN_CYCLES);

        // Unknown opcodes in both class groups
        for (int n = 0; n < BAD_COUNT; n++) begin
            issue_op((n % 2 == 1) ? multi_class() : alu_class(), BAD_CODES[n % 4],
                     vint_pkg::data_t'($random(seed)), vint_pkg::data_t'($random(seed)), 1'b1);
        end
        idle_cycles(DRAIN_CYCLES);

        if (ex1_q.size() != 0 || ex3_q.size() != 0 || ex4_q.size() != 0) begin
            $display("Results still outstanding at the end: ex1 %0d, ex3 %0d, ex4 %0d",
                     ex1_q.size(), ex3_q.size(), ex4_q.size());
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

//--- verilog/vint_alu.sv
// Single-cycle integer operations, result available in ex1
`timescale 1ns/1ps
`default_nettype none

module vint_alu (
    vint_req_if.alu                req,
    output logic                   ready_o,
    output vint_pkg::data_t        result_o
);

    vint_pkg::data_t a;
    vint_pkg::data_t b;
    vint_pkg::data_t result;
    logic            known;

    assign a = req.operand_a;
    assign b = req.operand_b;

    always_comb begin
        known = 1'b1;
        case (req.funct6)
            vint_pkg::FUNCT6_VADD:  result = a + b;
            // vs2 minus vs1
            vint_pkg::FUNCT6_VSUB:  result = b - a;
            vint_pkg::FUNCT6_VRSUB: result = a - b;
            vint_pkg::FUNCT6_VAND:  result = a & b;
            vint_pkg::FUNCT6_VOR:   result = a | b;
            vint_pkg::FUNCT6_VXOR:  result = a ^ b;
            // Shift amount from the low bits of a
            vint_pkg::FUNCT6_VSLL:  result = b << a[4:0];
            vint_pkg::FUNCT6_VSRL:  result = b >> a[4:0];
            vint_pkg::FUNCT6_VSRA:  result = vint_pkg::data_t'($signed(b) >>> a[4:0]);
            vint_pkg::FUNCT6_VMINU: result = (b < a) ? b : a;
            vint_pkg::FUNCT6_VMIN:  result = ($signed(b) < $signed(a)) ? b : a;
            vint_pkg::FUNCT6_VMAXU: result = (b > a) ? b : a;
            vint_pkg::FUNCT6_VMAX:  result = ($signed(b) > $signed(a)) ? b : a;
            vint_pkg::FUNCT6_VMV:   result = a;
            default: begin
                result = '0;
                known  = 1'b0;
            end
        endcase
    end

    assign ready_o  = req.alu_valid & known;
    // Masked-off elements write zero
    assign result_o = req.mask ? result : '0;

endmodule

`default_nettype wire

//--- verilog/vint_issue.sv
// Issue logic for the vector integer unit
// Routes each operation to the ALU, the multiplier or the divider
`timescale 1ns/1ps
`default_nettype none

module vint_issue (
    input  wire logic              valid_i,
    input  wire vint_pkg::funct3_t funct3_i,
    input  wire vint_pkg::funct6_t funct6_i,
    input  wire vint_pkg::data_t   data_a_i,
    input  wire vint_pkg::data_t   data_b_i,
    input  wire logic              mask_i,
    vint_req_if.issue              req
);

    logic is_multi_cycle;
    logic is_mul_family;
    logic is_div_family;

    assign is_multi_cycle = (funct3_i == vint_pkg::FUNCT3_OPMVV) ||
                            (funct3_i == vint_pkg::FUNCT3_OPMVX);

    // Families share the upper four opcode bits
    assign is_mul_family = (funct6_i[5:2] == vint_pkg::FUNCT6_VMULHU[5:2]);
    assign is_div_family = (funct6_i[5:2] == vint_pkg::FUNCT6_VDIVU[5:2]);

    assign req.alu_valid = valid_i & ~is_multi_cycle;
    assign req.mul_valid = valid_i & is_multi_cycle & is_mul_family;
    assign req.div_valid = valid_i & is_multi_cycle & is_div_family;

    assign req.funct6    = funct6_i;
    assign req.operand_a = data_a_i;
    assign req.operand_b = data_b_i;
    assign req.mask      = mask_i;

endmodule

`default_nettype wire

//--- verilog/vint_unit.sv
// Vector integer unit for one lane
// Joins issue logic with the ALU, multiplier and divider pipelines
`timescale 1ns/1ps
`default_nettype none

module vint_unit (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              valid_i,
    input  wire vint_pkg::data_t   data_a_i,
    input  wire vint_pkg::data_t   data_b_i,
    input  wire vint_pkg::funct6_t funct6_i,
    input  wire vint_pkg::funct3_t funct3_i,
    input  wire logic              mask_i,
    output logic                   ready_res_ex1_o,
    output vint_pkg::data_t        result_ex1_o,
    output logic                   ready_res_ex3_o,
    output vint_pkg::data_t        result_ex3_o,
    output logic                   ready_res_ex4_o,
    output vint_pkg::data_t        result_ex4_o
);

    vint_req_if req ();

    vint_issue u_issue (
        .valid_i  (valid_i),
        .funct3_i (funct3_i),
        .funct6_i (funct6_i),
        .data_a_i (data_a_i),
        .data_b_i (data_b_i),
        .mask_i   (mask_i),
        .req      (req)
    );

    // Result in ex1, same cycle as issue
    vint_alu u_alu (
        .req      (req),
        .ready_o  (ready_res_ex1_o),
        .result_o (result_ex1_o)
    );

    vint_mul u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ready_o  (ready_res_ex3_o),
        .result_o (result_ex3_o)
    );

    vint_div u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ready_o  (ready_res_ex4_o),
        .result_o (result_ex4_o)
    );

endmodule

`default_nettype wire
